// File: include/commit_params.svh
// ISA width and register file size macros for the commit unit
`ifndef COMMIT_PARAMS_SVH
`define COMMIT_PARAMS_SVH

// data path width, RV64
`define XLEN 64

// instruction word width, no compressed instructions
`define ILEN 32

// integer register file
`define NUM_GPR 32
`define GPR_IDX_W 5

`endif

// File: logic/rv_isa_pkg.sv
// ISA-side types: major opcodes, register index, a0 index

`include "commit_params.svh"

package rv_isa_pkg;

  // major opcode field, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_SYSTEM = 7'h73,
    OPC_TRAP   = 7'h6b  // simulation trap, ends the run
  } opcode_e;

  // integer register index
  typedef logic [`GPR_IDX_W-1:0] gpr_idx_t;

  // a0 holds the trap code
  localparam gpr_idx_t GPR_A0 = gpr_idx_t'(10);

endpackage

// File: logic/commit_pkg.sv
// commit-side types: data word, instruction word, control state

`include "commit_params.svh"

package commit_pkg;

  // architectural data word
  typedef logic [`XLEN-1:0] xlen_t;

  // raw instruction word
  typedef logic [`ILEN-1:0] inst_t;

  // commit control state
  typedef enum logic {
    ST_RUN  = 1'b0,  // accepting commits
    ST_HALT = 1'b1   // trap seen, wait for reset
  } cmt_state_e;

endpackage

// File: logic/commit_ctrl.sv
// run/halt control for the commit unit
// qualifies commits and interrupts, detects the simulation trap
`timescale 1ns/1ns

`include "commit_params.svh"

module commit_ctrl
  import rv_isa_pkg::*;
  import commit_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        i_cmt_valid,
  input  inst_t       i_inst,
  input  logic [31:0] i_intr_no,
  output logic        o_commit_en,
  output logic        o_intr_take,
  output logic        o_trap_take,
  output logic        o_running
);

  cmt_state_e state_q;
  cmt_state_e state_d;
  opcode_e    opcode;
  logic       intr_pending;
  logic       is_trap;

  assign opcode       = opcode_e'(i_inst[6:0]);
  assign is_trap      = (opcode == OPC_TRAP);
  assign intr_pending = (i_intr_no != '0);

  assign o_running = (state_q == ST_RUN);

  // an interrupt replaces the instruction in the same slot
  assign o_commit_en = o_running & i_cmt_valid & ~intr_pending;
  assign o_intr_take = o_running & i_cmt_valid & intr_pending;
  assign o_trap_take = o_commit_en & is_trap;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_RUN: begin
        if (o_trap_take) begin
          state_d = ST_HALT;  // last retired inst
        end
      end
      ST_HALT: begin
        state_d = ST_HALT;  // only reset leaves
      end
      default: begin
        state_d = ST_RUN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_RUN;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: logic/commit_record.sv
// registered difftest commit record, interrupt event and trap event
`timescale 1ns/1ns

`include "commit_params.svh"

module commit_record
  import rv_isa_pkg::*;
  import commit_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        i_commit_en,
  input  logic        i_intr_take,
  input  logic        i_trap_take,
  input  xlen_t       i_pc,
  input  inst_t       i_inst,
  input  gpr_idx_t    i_rd,
  input  logic        i_rd_wen,
  input  xlen_t       i_rd_wdata,
  input  logic        i_skip,
  input  logic [31:0] i_intr_no,
  input  xlen_t       i_a0,
  output logic        o_cmt_valid,
  output xlen_t       o_cmt_pc,
  output inst_t       o_cmt_inst,
  output logic        o_cmt_wen,
  output gpr_idx_t    o_cmt_wdest,
  output xlen_t       o_cmt_wdata,
  output logic        o_cmt_skip,
  output logic        o_intr_valid,
  output logic [31:0] o_intr_no,
  output xlen_t       o_intr_pc,
  output logic        o_trap,
  output logic [7:0]  o_trap_code
);

  // pulses and sticky trap
  always_ff @(posedge clk) begin
    if (rst) begin
      o_cmt_valid  <= 1'b0;
      o_intr_valid <= 1'b0;
      o_trap       <= 1'b0;
      o_trap_code  <= 8'h00;
    end else begin
      o_cmt_valid  <= i_commit_en;
      o_intr_valid <= i_intr_take;
      if (i_trap_take) begin
        o_trap      <= 1'b1;
        o_trap_code <= i_a0[7:0];  // a0 before this inst
      end
    end
  end

  // commit fields hold until the next commit
  always_ff @(posedge clk) begin
    if (i_commit_en) begin
      o_cmt_pc    <= i_pc;
      o_cmt_inst  <= i_inst;
      o_cmt_wen   <= i_rd_wen;
      o_cmt_wdest <= i_rd;
      o_cmt_wdata <= i_rd_wdata;
      o_cmt_skip  <= i_skip;
    end
  end

  always_ff @(posedge clk) begin
    if (i_intr_take) begin
      o_intr_no <= i_intr_no;
      o_intr_pc <= i_pc;  // pc of the interrupted slot
    end
  end

endmodule

// File: logic/arch_reg_shadow.sv
// shadow integer register file with a0 and debug read ports
`timescale 1ns/1ns

`include "commit_params.svh"

module arch_reg_shadow
  import rv_isa_pkg::*;
  import commit_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     i_wen,
  input  gpr_idx_t i_waddr,
  input  xlen_t    i_wdata,
  input  gpr_idx_t i_raddr,
  output xlen_t    o_rdata,
  output xlen_t    o_a0
);

  xlen_t regs [`NUM_GPR];
  logic  wr_ok;

  // x0 never written, stays zero from reset
  assign wr_ok = i_wen & (i_waddr != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_GPR; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata = regs[i_raddr];  // debug port
  assign o_a0    = regs[GPR_A0];

endmodule

// File: logic/commit_counters.sv
// cycle and retired-instruction counters, frozen once halted
`timescale 1ns/1ns

`include "commit_params.svh"

module commit_counters
  import commit_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  i_running,
  input  logic  i_commit_en,
  output xlen_t o_cycle_cnt,
  output xlen_t o_instr_cnt
);

  xlen_t cycle_inc;
  xlen_t instr_inc;

  assign cycle_inc = {{(`XLEN-1){1'b0}}, i_running};
  assign instr_inc = {{(`XLEN-1){1'b0}}, i_commit_en};  // low after halt too

  always_ff @(posedge clk) begin
    if (rst) begin
      o_cycle_cnt <= '0;
      o_instr_cnt <= '0;
    end else begin
      o_cycle_cnt <= o_cycle_cnt + cycle_inc;
      o_instr_cnt <= o_instr_cnt + instr_inc;
    end
  end

endmodule

// File: logic/commit_unit.sv
// commit unit top: control, record, shadow registers and counters
`timescale 1ns/1ns

`include "commit_params.svh"

module commit_unit
  import rv_isa_pkg::*;
  import commit_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        i_cmt_valid,
  input  xlen_t       i_pc,
  input  inst_t       i_inst,
  input  gpr_idx_t    i_rd,
  input  logic        i_rd_wen,
  input  xlen_t       i_rd_wdata,
  input  logic        i_skip,
  input  logic [31:0] i_intr_no,
  input  gpr_idx_t    i_gpr_raddr,
  output logic        o_cmt_valid,
  output xlen_t       o_cmt_pc,
  output inst_t       o_cmt_inst,
  output logic        o_cmt_wen,
  output gpr_idx_t    o_cmt_wdest,
  output xlen_t       o_cmt_wdata,
  output logic        o_cmt_skip,
  output logic        o_intr_valid,
  output logic [31:0] o_intr_no,
  output xlen_t       o_intr_pc,
  output logic        o_trap,
  output logic [7:0]  o_trap_code,
  output xlen_t       o_cycle_cnt,
  output xlen_t       o_instr_cnt,
  output xlen_t       o_gpr_rdata
);

  logic  commit_en;
  logic  intr_take;
  logic  trap_take;
  logic  running;
  logic  shadow_wen;
  xlen_t a0;

  assign shadow_wen = commit_en & i_rd_wen;  // skip still writes

  commit_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .i_cmt_valid (i_cmt_valid),
    .i_inst      (i_inst),
    .i_intr_no   (i_intr_no),
    .o_commit_en (commit_en),
    .o_intr_take (intr_take),
    .o_trap_take (trap_take),
    .o_running   (running)
  );

  commit_record u_record (
    .clk          (clk),
    .rst          (rst),
    .i_commit_en  (commit_en),
    .i_intr_take  (intr_take),
    .i_trap_take  (trap_take),
    .i_pc         (i_pc),
    .i_inst       (i_inst),
    .i_rd         (i_rd),
    .i_rd_wen     (i_rd_wen),
    .i_rd_wdata   (i_rd_wdata),
    .i_skip       (i_skip),
    .i_intr_no    (i_intr_no),
    .i_a0         (a0),
    .o_cmt_valid  (o_cmt_valid),
    .o_cmt_pc     (o_cmt_pc),
    .o_cmt_inst   (o_cmt_inst),
    .o_cmt_wen    (o_cmt_wen),
    .o_cmt_wdest  (o_cmt_wdest),
    .o_cmt_wdata  (o_cmt_wdata),
    .o_cmt_skip   (o_cmt_skip),
    .o_intr_valid (o_intr_valid),
    .o_intr_no    (o_intr_no),
    .o_intr_pc    (o_intr_pc),
    .o_trap       (o_trap),
    .o_trap_code  (o_trap_code)
  );

  arch_reg_shadow u_shadow (
    .clk     (clk),
    .rst     (rst),
    .i_wen   (shadow_wen),
    .i_waddr (i_rd),
    .i_wdata (i_rd_wdata),
    .i_raddr (i_gpr_raddr),
    .o_rdata (o_gpr_rdata),
    .o_a0    (a0)
  );

  commit_counters u_counters (
    .clk         (clk),
    .rst         (rst),
    .i_running   (running),
    .i_commit_en (commit_en),
    .o_cycle_cnt (o_cycle_cnt),
    .o_instr_cnt (o_instr_cnt)
  );

endmodule

// File: verif/commit_unit_tb.sv
// testbench for the commit unit
// stimulus table, reference model, value checks and summary
`timescale 1ns/1ns

`include "commit_params.svh"

module commit_unit_tb
  import rv_isa_pkg::*;
  import commit_pkg::*;
;

  logic        clk;
  logic        rst;
  logic        i_cmt_valid;
  xlen_t       i_pc;
  inst_t       i_inst;
  gpr_idx_t    i_rd;
  logic        i_rd_wen;
  xlen_t       i_rd_wdata;
  logic        i_skip;
  logic [31:0] i_intr_no;
  gpr_idx_t    i_gpr_raddr;
  logic        o_cmt_valid;
  xlen_t       o_cmt_pc;
  inst_t       o_cmt_inst;
  logic        o_cmt_wen;
  gpr_idx_t    o_cmt_wdest;
  xlen_t       o_cmt_wdata;
  logic        o_cmt_skip;
  logic        o_intr_valid;
  logic [31:0] o_intr_no;
  xlen_t       o_intr_pc;
  logic        o_trap;
  logic [7:0]  o_trap_code;
  xlen_t       o_cycle_cnt;
  xlen_t       o_instr_cnt;
  xlen_t       o_gpr_rdata;

  // stimulus table
  int          n_rows = 0;
  logic        t_valid [32];
  xlen_t       t_pc    [32];
  opcode_e     t_opc   [32];
  gpr_idx_t    t_rd    [32];
  logic        t_wen   [32];
  xlen_t       t_data  [32];
  logic        t_skip  [32];
  logic [31:0] t_intr  [32];

  // reference model state
  xlen_t       m_regs [`NUM_GPR];
  logic        m_running = 1'b1;
  logic        have_cmt = 1'b0;
  logic        have_intr = 1'b0;
  logic        exp_cmt_valid = 1'b0;
  xlen_t       exp_pc;
  inst_t       exp_inst;
  logic        exp_wen;
  gpr_idx_t    exp_wdest;
  xlen_t       exp_wdata;
  logic        exp_skip;
  logic        exp_intr_valid = 1'b0;
  logic [31:0] exp_intr_no;
  xlen_t       exp_intr_pc;
  logic        exp_trap = 1'b0;
  logic [7:0]  exp_trap_code = 8'h00;
  xlen_t       exp_cycle = '0;
  xlen_t       exp_instr = '0;

  integer      seed = 32'hbcfb_5a08;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  logic        timed_out = 1'b0;

  commit_unit dut0 (
    .clk          (clk),
    .rst          (rst),
    .i_cmt_valid  (i_cmt_valid),
    .i_pc         (i_pc),
    .i_inst       (i_inst),
    .i_rd         (i_rd),
    .i_rd_wen     (i_rd_wen),
    .i_rd_wdata   (i_rd_wdata),
    .i_skip       (i_skip),
    .i_intr_no    (i_intr_no),
    .i_gpr_raddr  (i_gpr_raddr),
    .o_cmt_valid  (o_cmt_valid),
    .o_cmt_pc     (o_cmt_pc),
    .o_cmt_inst   (o_cmt_inst),
    .o_cmt_wen    (o_cmt_wen),
    .o_cmt_wdest  (o_cmt_wdest),
    .o_cmt_wdata  (o_cmt_wdata),
    .o_cmt_skip   (o_cmt_skip),
    .o_intr_valid (o_intr_valid),
    .o_intr_no    (o_intr_no),
    .o_intr_pc    (o_intr_pc),
    .o_trap       (o_trap),
    .o_trap_code  (o_trap_code),
    .o_cycle_cnt  (o_cycle_cnt),
    .o_instr_cnt  (o_instr_cnt),
    .o_gpr_rdata  (o_gpr_rdata)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  function automatic inst_t make_inst(input opcode_e opc, input gpr_idx_t rd,
                                      input logic [7:0] tag);
    return {tag, 12'h0a5, rd, opc};  // tag keeps rows apart
  endfunction

  task automatic add_row(input logic v, input xlen_t pc, input opcode_e opc, input gpr_idx_t rd,
                         input logic wen, input xlen_t data, input logic rnd, input logic skip,
                         input logic [31:0] intr);
    t_valid[n_rows] = v;
    t_pc[n_rows]    = pc;
    t_opc[n_rows]   = opc;
    t_rd[n_rows]    = rd;
    t_wen[n_rows]   = wen;
    t_data[n_rows]  = rnd ? {$random(seed), $random(seed)} : data;
    t_skip[n_rows]  = skip;
    t_intr[n_rows]  = intr;
    n_rows++;
  endtask

  task automatic build_table();
    //      valid pc              opcode      rd  wen  data     rnd  skip intr
    add_row(1'b1, 64'h8000_0000, OPC_OP_IMM, 1,  1'b1, 64'h11,  1'b0, 1'b0, 0);
    add_row(1'b1, 64'h8000_0004, OPC_OP,     2,  1'b1, '0,      1'b1, 1'b0, 0);
    add_row(1'b0, 64'h8000_0008, OPC_OP,     3,  1'b1, 64'hdead, 1'b0, 1'b0, 0);  // bubble
    add_row(1'b1, 64'h8000_0008, OPC_LUI,    0,  1'b1, 64'hffff, 1'b0, 1'b0, 0);  // x0
    add_row(1'b1, 64'h8000_000c, OPC_OP_IMM, 3,  1'b0, 64'h1234, 1'b0, 1'b0, 0);  // no wen
    add_row(1'b1, 64'h8000_0010, OPC_LOAD,   4,  1'b1, '0,      1'b1, 1'b1, 0);  // skip
    add_row(1'b1, 64'h8000_0014, OPC_OP,     10, 1'b1, 64'h1c5a, 1'b0, 1'b0, 0);
    add_row(1'b1, 64'h8000_0018, OPC_OP_IMM, 5,  1'b1, '0,      1'b1, 1'b0, 7);  // interrupt
    add_row(1'b1, 64'h8000_0018, OPC_OP_IMM, 5,  1'b1, '0,      1'b1, 1'b0, 0);
    add_row(1'b0, 64'h8000_001c, OPC_OP,     6,  1'b1, '0,      1'b1, 1'b0, 0);
    add_row(1'b1, 64'h8000_001c, OPC_SYSTEM, 0,  1'b0, '0,      1'b0, 1'b1, 0);
    add_row(1'b1, 64'h8000_0020, OPC_OP,     31, 1'b1, '0,      1'b1, 1'b0, 0);
    add_row(1'b1, 64'h8000_0024, OPC_OP,     1,  1'b1, '0,      1'b1, 1'b0, 0);
    add_row(1'b0, 64'h8000_0028, OPC_OP,     7,  1'b1, '0,      1'b1, 1'b0, 3);  // gated
    add_row(1'b1, 64'h8000_0028, OPC_OP_IMM, 10, 1'b1, '0,      1'b1, 1'b0, 0);
    add_row(1'b1, 64'h8000_002c, OPC_LOAD,   6,  1'b1, '0,      1'b1, 1'b1, 0);
    add_row(1'b1, 64'h8000_0030, OPC_OP,     8,  1'b1, '0,      1'b1, 1'b0, 11);
    add_row(1'b1, 64'h8000_0030, OPC_OP_IMM, 10, 1'b1, 64'h42,  1'b0, 1'b0, 0);
    add_row(1'b1, 64'h8000_0034, OPC_TRAP,   10, 1'b1, 64'h77,  1'b0, 1'b0, 0);  // trap
    add_row(1'b1, 64'h8000_0038, OPC_OP,     7,  1'b1, '0,      1'b1, 1'b0, 0);
    add_row(1'b1, 64'h8000_003c, OPC_OP,     9,  1'b1, '0,      1'b1, 1'b0, 5);
    add_row(1'b1, 64'h8000_0040, OPC_TRAP,   10, 1'b1, 64'h99,  1'b0, 1'b0, 0);
    add_row(1'b0, 64'h8000_0044, OPC_OP,     2,  1'b1, '0,      1'b1, 1'b0, 0);
    add_row(1'b1, 64'h8000_0044, OPC_OP_IMM, 1,  1'b1, '0,      1'b1, 1'b0, 0);
  endtask

  task automatic check_outputs(input gpr_idx_t raddr);
    check_val("o_cmt_valid", 64'(o_cmt_valid), 64'(exp_cmt_valid));
    check_val("o_intr_valid", 64'(o_intr_valid), 64'(exp_intr_valid));
    check_val("o_trap", 64'(o_trap), 64'(exp_trap));
    check_val("o_trap_code", 64'(o_trap_code), 64'(exp_trap_code));
    check_val("o_cycle_cnt", o_cycle_cnt, exp_cycle);
    check_val("o_instr_cnt", o_instr_cnt, exp_instr);
    check_val("o_gpr_rdata", o_gpr_rdata, m_regs[raddr]);
    if (have_cmt) begin
      check_val("o_cmt_pc", o_cmt_pc, exp_pc);
      check_val("o_cmt_inst", 64'(o_cmt_inst), 64'(exp_inst));
      check_val("o_cmt_wen", 64'(o_cmt_wen), 64'(exp_wen));
      check_val("o_cmt_wdest", 64'(o_cmt_wdest), 64'(exp_wdest));
      check_val("o_cmt_wdata", o_cmt_wdata, exp_wdata);
      check_val("o_cmt_skip", 64'(o_cmt_skip), 64'(exp_skip));
    end
    if (have_intr) begin
      check_val("o_intr_no", 64'(o_intr_no), 64'(exp_intr_no));
      check_val("o_intr_pc", o_intr_pc, exp_intr_pc);
    end
  endtask

  // entered and left at a falling edge
  task automatic apply_cycle(input logic v, input xlen_t pc, input inst_t inst, input gpr_idx_t rd,
                             input logic wen, input xlen_t data, input logic skip,
                             input logic [31:0] intr, input gpr_idx_t raddr);
    logic commit;
    logic take_intr;
    logic trap;
    i_cmt_valid = v;
    i_pc        = pc;
    i_inst      = inst;
    i_rd        = rd;
    i_rd_wen    = wen;
    i_rd_wdata  = data;
    i_skip      = skip;
    i_intr_no   = intr;
    i_gpr_raddr = raddr;
    commit    = m_running && v && (intr == 32'd0);
    take_intr = m_running && v && (intr != 32'd0);
    trap      = commit && (inst[6:0] == OPC_TRAP);
    exp_cmt_valid  = commit;
    exp_intr_valid = take_intr;
    if (commit) begin
      have_cmt  = 1'b1;
      exp_pc    = pc;
      exp_inst  = inst;
      exp_wen   = wen;
      exp_wdest = rd;
      exp_wdata = data;
      exp_skip  = skip;
      exp_instr = exp_instr + 64'd1;
    end
    if (take_intr) begin
      have_intr   = 1'b1;
      exp_intr_no = intr;
      exp_intr_pc = pc;
    end
    if (trap) begin
      exp_trap      = 1'b1;
      exp_trap_code = m_regs[GPR_A0][7:0];  // a0 before the trap writes
    end
    if (m_running) begin
      exp_cycle = exp_cycle + 64'd1;
    end
    if (commit && wen && rd != '0) begin
      m_regs[rd] = data;
    end
    if (trap) begin
      m_running = 1'b0;
    end
    @(posedge clk);
    #1;
    check_outputs(raddr);
    @(negedge clk);
  endtask

  task automatic wait_for_trap();
    int n;
    n = 0;
    while (o_trap !== 1'b1 && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (o_trap !== 1'b1) begin
      $display("timeout: o_trap did not rise within %0d cycles of the trap commit", n);
      timed_out = 1'b1;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d mismatches", test_cnt, name, err_cnt - err_before);
    end
  endtask

  initial begin
    int err_before;
    logic trap_seen;
    trap_seen   = 1'b0;
    rst         = 1'b1;
    i_cmt_valid = 1'b0;
    i_pc        = '0;
    i_inst      = '0;
    i_rd        = '0;
    i_rd_wen    = 1'b0;
    i_rd_wdata  = '0;
    i_skip      = 1'b0;
    i_intr_no   = '0;
    i_gpr_raddr = '0;
    for (int r = 0; r < `NUM_GPR; r++) begin
      m_regs[r] = '0;
    end
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);

    err_before = err_cnt;
    check_outputs('0);
    finish_test("reset outputs", err_before);
    rst = 1'b0;

    err_before = err_cnt;
    for (int r = 0; r < `NUM_GPR; r++) begin
      apply_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, '0, gpr_idx_t'(r));
    end
    finish_test("register scan after reset", err_before);

    for (int t = 0; t < n_rows && !timed_out; t++) begin
      err_before = err_cnt;
      apply_cycle(t_valid[t], t_pc[t], make_inst(t_opc[t], t_rd[t], 8'(t)), t_rd[t],
                  t_wen[t], t_data[t], t_skip[t], t_intr[t], t_rd[t]);
      if (exp_trap && !trap_seen) begin
        wait_for_trap();
        trap_seen = 1'b1;
      end
      finish_test($sformatf("row %0d", t), err_before);
    end

    if (!timed_out) begin
      err_before = err_cnt;
      for (int r = 0; r < `NUM_GPR; r++) begin
        apply_cycle(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, '0, gpr_idx_t'(r));
      end
      finish_test("register scan after halt", err_before);
    end

    $display("tests %0d, ok %0d, failing %0d, value errors %0d",
             test_cnt, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
logic/rv_isa_pkg.sv
logic/commit_pkg.sv
logic/commit_ctrl.sv
logic/commit_record.sv
logic/arch_reg_shadow.sv
logic/commit_counters.sv
logic/commit_unit.sv
verif/commit_unit_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ns -f flist.f --top-module commit_unit_tb -Mdir obj_dir
	./obj_dir/Vcommit_unit_tb | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
